// File: build.f
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/pipe_ctrl_pkg.sv
rtl/id_ex_bus_if.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/id_ex_stage_reg.sv
rtl/execute_stage.sv
rtl/exec_slice_top.sv
tb/exec_slice_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module exec_slice_tb -f build.f -o exec_slice_sim

status=0
./obj_dir/exec_slice_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation failed"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "simulator exited with status $status"
    exit "$status"
fi
echo "simulation passed"

// File: tb/exec_slice_tb.sv
`default_nettype none

`include "core_settings.svh"

module exec_slice_tb;

    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 10;
    localparam int RANDOM_SEED    = 48235;
    localparam int MAX_BUSY_TOTAL = 40;
    localparam int DRAIN_CYCLES   = 6;
    localparam int FLUSH_IDX      = 26;

    localparam int F7_BASE = 0;
    localparam int F7_ALT  = 32;     // sub.
    localparam int F3_ADD  = 0;
    localparam int F3_SLL  = 1;
    localparam int F3_SLT  = 2;
    localparam int F3_XOR  = 4;
    localparam int F3_SRL  = 5;
    localparam int F3_OR   = 6;
    localparam int F3_AND  = 7;
    localparam int F3_BEQ  = 0;
    localparam int F3_BNE  = 1;

    logic                 clk_i;
    logic                 arst_n_i;
    logic                 busywait_i;
    logic                 flush_i;
    rv_isa_pkg::pc_t      pc_i;
    rv_isa_pkg::word_t    instr_i;
    logic                 stall_o;
    logic                 redirect_o;
    rv_isa_pkg::pc_t      redirect_pc_o;
    logic                 wb_en_o;
    rv_isa_pkg::reg_idx_t wb_rd_o;
    rv_isa_pkg::word_t    wb_data_o;

    rv_isa_pkg::word_t    program_rom [$];
    string                exp_name [$];
    rv_isa_pkg::reg_idx_t exp_rd [$];
    rv_isa_pkg::word_t    exp_data [$];

    exec_slice_top u_exec_slice_top (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .busywait_i    (busywait_i),
        .flush_i       (flush_i),
        .pc_i          (pc_i),
        .instr_i       (instr_i),
        .stall_o       (stall_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o),
        .wb_en_o       (wb_en_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o)
    );

    always #(CLK_PERIOD/2) clk_i = ~clk_i;

    function automatic rv_isa_pkg::word_t op_word(input int f7, input int f3, input int rd,
                                                  input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic rv_isa_pkg::word_t op_imm_word(input int f3, input int rd, input int rs1,
                                                      input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
    endfunction

    function automatic rv_isa_pkg::word_t lui_word(input int rd, input int imm);
        return {imm[19:0], rd[4:0], 7'b0110111};
    endfunction

    // offset is in bytes.
    function automatic rv_isa_pkg::word_t branch_word(input int f3, input int rs1, input int rs2,
                                                      input int offset);
        return {offset[12], offset[10:5], rs2[4:0], rs1[4:0], f3[2:0], offset[4:1], offset[11],
                7'b1100011};
    endfunction

    // rd 0 marks an instruction that must never retire.
    task automatic add_instr(input rv_isa_pkg::word_t instr, input string name, input int rd,
                             input rv_isa_pkg::word_t data);
        program_rom.push_back(instr);
        if (rd != 0) begin
            exp_name.push_back(name);
            exp_rd.push_back(rd[4:0]);
            exp_data.push_back(data);
        end
    endtask

    task automatic load_program();
        add_instr(op_imm_word(F3_ADD, 1, 0, 5), "addi x1", 1, 32'h0000_0005);
        add_instr(op_imm_word(F3_ADD, 2, 0, -3), "addi x2 negative", 2, 32'hFFFF_FFFD);
        add_instr(lui_word(3, 32'h12345), "lui x3", 3, 32'h1234_5000);
        add_instr(op_word(F7_BASE, F3_ADD, 4, 1, 2), "add wb bypass", 4, 32'h0000_0002);
        add_instr(op_word(F7_ALT, F3_ADD, 5, 1, 2), "sub", 5, 32'h0000_0008);
        add_instr(op_word(F7_BASE, F3_AND, 6, 3, 2), "and", 6, 32'h1234_5000);
        add_instr(op_word(F7_BASE, F3_OR, 7, 1, 3), "or", 7, 32'h1234_5005);
        add_instr(op_word(F7_BASE, F3_XOR, 8, 3, 2), "xor", 8, 32'hEDCB_AFFD);
        add_instr(op_word(F7_BASE, F3_SLT, 9, 2, 1), "slt negative lhs", 9, 32'h0000_0001);
        add_instr(op_word(F7_BASE, F3_SLT, 10, 1, 2), "slt negative rhs", 10, 32'h0000_0000);
        add_instr(op_word(F7_BASE, F3_SLL, 11, 1, 4), "sll", 11, 32'h0000_0014);
        add_instr(op_word(F7_BASE, F3_SRL, 12, 3, 5), "srl", 12, 32'h0012_3450);
        add_instr(op_imm_word(F3_ADD, 13, 1, 10), "addi x13", 13, 32'h0000_000F);
        add_instr(op_word(F7_BASE, F3_ADD, 14, 13, 1), "add after stall", 14, 32'h0000_0014);
        add_instr(op_imm_word(F3_XOR, 15, 14, 32'h0F0), "xori after stall", 15, 32'h0000_00E4);
        add_instr(op_imm_word(F3_AND, 16, 2, 32'h7F0), "andi", 16, 32'h0000_07F0);
        add_instr(op_imm_word(F3_OR, 17, 0, -16), "ori", 17, 32'hFFFF_FFF0);
        add_instr(op_imm_word(F3_SLT, 18, 2, -2), "slti", 18, 32'h0000_0001);
        add_instr(branch_word(F3_BEQ, 1, 13, 8), "", 0, '0);    // not taken.
        add_instr(branch_word(F3_BNE, 1, 13, 8), "", 0, '0);    // taken, skips the next one.
        add_instr(op_imm_word(F3_ADD, 19, 0, 32'h7FF), "", 0, '0);
        add_instr(op_imm_word(F3_ADD, 20, 0, 100), "addi branch target", 20, 32'h0000_0064);
        add_instr(branch_word(F3_BEQ, 1, 1, 8), "", 0, '0);
        add_instr(op_imm_word(F3_ADD, 21, 0, 1), "", 0, '0);
        add_instr(op_imm_word(F3_ADD, 0, 0, 55), "", 0, '0);    // x0 destination.
        add_instr(32'h0000_2283, "", 0, '0);                     // lw, outside the subset.
        add_instr(op_imm_word(F3_ADD, 22, 0, 33), "", 0, '0);   // hit by the flush.
        add_instr(op_imm_word(F3_ADD, 23, 20, 1), "addi after flush", 23, 32'h0000_0065);
        add_instr(op_word(F7_ALT, F3_ADD, 24, 23, 20), "sub after stall", 24, 32'h0000_0001);
        add_instr(lui_word(25, 32'hFFFFF), "lui x25", 25, 32'hFFFF_F000);
        add_instr(op_word(F7_BASE, F3_SRL, 26, 25, 4), "srl after stall", 26, 32'h3FFF_FC00);
        add_instr(op_word(F7_BASE, F3_SLL, 27, 25, 12), "sll low five bits", 27, 32'hF000_0000);
    endtask

    task automatic stop_with_failure();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input rv_isa_pkg::word_t expected,
                               input rv_isa_pkg::word_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    initial begin
        int              fetch_idx;
        int              busy_left;
        int              busy_total;
        int              ret_count;
        int              cycle_count;
        int              cycle_limit;
        int              drain_left;
        logic            stall_s;
        logic            redirect_s;
        logic            busy_s;
        logic            flush_done;
        rv_isa_pkg::pc_t target_s;

        clk_i      = 1'b0;
        arst_n_i   = 1'b0;
        busywait_i = 1'b0;
        flush_i    = 1'b0;
        pc_i       = '0;
        instr_i    = `NOP_INSTR;
        fetch_idx  = -1;                // first advance lands on word 0.
        busy_left  = 0;
        busy_total = 0;
        ret_count  = 0;
        cycle_count = 0;
        drain_left = DRAIN_CYCLES;
        stall_s    = 1'b0;
        redirect_s = 1'b0;
        busy_s     = 1'b0;
        flush_done = 1'b0;
        target_s   = '0;
        void'($urandom(RANDOM_SEED));
        load_program();
        cycle_limit = exp_data.size() * 4 + MAX_BUSY_TOTAL + DRAIN_CYCLES;

        repeat (RESET_CYCLES) @(negedge clk_i);
        check_value("reset outputs", '0, rv_isa_pkg::word_t'({stall_o, redirect_o, wb_en_o}));
        arst_n_i = 1'b1;

        while (drain_left > 0) begin
            if (!busy_s) begin
                if (redirect_s) begin
                    fetch_idx = int'(target_s);
                end else if (!stall_s) begin
                    fetch_idx++;
                end
            end
            flush_i = 1'b0;
            if ((fetch_idx == FLUSH_IDX) && !flush_done) begin
                flush_i    = 1'b1;          // drops the instruction presented now.
                flush_done = 1'b1;
                busywait_i = 1'b0;
            end else begin
                if ((busy_left == 0) && (busy_total < MAX_BUSY_TOTAL) && (($urandom % 5) == 0)) begin
                    busy_left = 1 + int'($urandom % 4);
                end
                busywait_i = (busy_left > 0) && (busy_total < MAX_BUSY_TOTAL);
                if (busywait_i) begin
                    busy_left--;
                    busy_total++;
                end
            end
            pc_i    = rv_isa_pkg::pc_t'(fetch_idx);
            instr_i = (fetch_idx < program_rom.size()) ? program_rom[fetch_idx] : `NOP_INSTR;

            #(CLK_PERIOD/4);
            stall_s    = stall_o;
            redirect_s = redirect_o;
            target_s   = redirect_pc_o;
            busy_s     = busywait_i;
            if (wb_en_o) begin
                if (ret_count >= exp_data.size()) begin
                    $display("unexpected retirement of x%0d = 0x%08h after the last result",
                             wb_rd_o, wb_data_o);
                    stop_with_failure();
                end else begin
                    check_value({exp_name[ret_count], " rd"},
                                rv_isa_pkg::word_t'(exp_rd[ret_count]),
                                rv_isa_pkg::word_t'(wb_rd_o));
                    check_value({exp_name[ret_count], " data"}, exp_data[ret_count], wb_data_o);
                    ret_count++;
                end
            end
            if (ret_count == exp_data.size()) begin
                drain_left--;
            end
            cycle_count++;
            if (cycle_count > cycle_limit) begin
                $display("retirement stalled: %0d of %0d results seen after %0d cycles",
                         ret_count, exp_data.size(), cycle_count);
                stop_with_failure();
            end
            @(negedge clk_i);
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/exec_slice_top.sv
`default_nettype none

module exec_slice_top (
    input  wire logic                 clk_i,
    input  wire logic                 arst_n_i,
    input  wire logic                 busywait_i,
    input  wire logic                 flush_i,
    input  wire rv_isa_pkg::pc_t      pc_i,
    input  wire rv_isa_pkg::word_t    instr_i,
    output logic                      stall_o,
    output logic                      redirect_o,
    output rv_isa_pkg::pc_t           redirect_pc_o,
    output logic                      wb_en_o,
    output rv_isa_pkg::reg_idx_t      wb_rd_o,
    output rv_isa_pkg::word_t         wb_data_o
);

    id_ex_bus_if id_bus ();
    id_ex_bus_if ex_bus ();

    decode_stage u_decode_stage (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .pc_i       (pc_i),
        .instr_i    (instr_i),
        .id_bus     (id_bus),
        .ex_rd_i    (ex_bus.rd),
        .ex_wb_en_i (ex_bus.reg_wb_en),
        .hazard_o   (stall_o),
        .wb_en_i    (wb_en_o),
        .wb_rd_i    (wb_rd_o),
        .wb_data_i  (wb_data_o)
    );

    id_ex_stage_reg u_id_ex_stage_reg (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .busywait_i (busywait_i),
        .flush_i    (flush_i),
        .hazard_i   (stall_o),
        .redirect_i (redirect_o),
        .id_bus     (id_bus),
        .ex_bus     (ex_bus)
    );

    execute_stage u_execute_stage (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .busywait_i    (busywait_i),
        .ex_bus        (ex_bus),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o),
        .wb_en_o       (wb_en_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o)
    );

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
`default_nettype none

`include "core_settings.svh"

module execute_stage (
    input  wire logic             clk_i,
    input  wire logic             arst_n_i,
    input  wire logic             busywait_i,
    id_ex_bus_if.consumer         ex_bus,
    output logic                  redirect_o,
    output rv_isa_pkg::pc_t       redirect_pc_o,
    output logic                  wb_en_o,
    output rv_isa_pkg::reg_idx_t  wb_rd_o,
    output rv_isa_pkg::word_t     wb_data_o
);

    rv_isa_pkg::word_t op_a;
    rv_isa_pkg::word_t op_b;
    rv_isa_pkg::word_t alu_result;
    rv_isa_pkg::word_t target;
    logic              taken;
    logic              wb_en_q;

    assign op_a = (ex_bus.alu_a_sel == pipe_ctrl_pkg::SEL_A_ZERO) ? '0 : ex_bus.rs1_value;
    assign op_b = (ex_bus.alu_b_sel == pipe_ctrl_pkg::SEL_B_IMM) ?
                  ex_bus.imm_value : ex_bus.rs2_value;

    always_comb begin
        case (ex_bus.alu_op)
            pipe_ctrl_pkg::ALU_ADD:    alu_result = op_a + op_b;
            pipe_ctrl_pkg::ALU_SUB:    alu_result = op_a - op_b;
            pipe_ctrl_pkg::ALU_AND:    alu_result = op_a & op_b;
            pipe_ctrl_pkg::ALU_OR:     alu_result = op_a | op_b;
            pipe_ctrl_pkg::ALU_XOR:    alu_result = op_a ^ op_b;
            pipe_ctrl_pkg::ALU_SLT:    alu_result = {{(`XLEN-1){1'b0}},
                                                     $signed(op_a) < $signed(op_b)};
            pipe_ctrl_pkg::ALU_SLL:    alu_result = op_a << op_b[4:0];
            pipe_ctrl_pkg::ALU_SRL:    alu_result = op_a >> op_b[4:0];
            pipe_ctrl_pkg::ALU_PASS_B: alu_result = op_b;
            default:                   alu_result = '0;
        endcase
    end

    always_comb begin
        case (ex_bus.branch_sel)
            pipe_ctrl_pkg::BR_EQ: taken = (ex_bus.rs1_value == ex_bus.rs2_value);
            pipe_ctrl_pkg::BR_NE: taken = (ex_bus.rs1_value != ex_bus.rs2_value);
            default:              taken = 1'b0;
        endcase
    end

    // the branch stays in EX during busywait, redirect fires on release.
    assign target        = {ex_bus.pc, 2'b00} + ex_bus.imm_value;
    assign redirect_pc_o = target[`XLEN-1:2];
    assign redirect_o    = taken && !busywait_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_en_q <= 1'b0;
        end else if (!busywait_i) begin
            wb_en_q <= ex_bus.reg_wb_en;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!busywait_i) begin
            wb_rd_o   <= ex_bus.rd;
            wb_data_o <= alu_result;
        end
    end

    assign wb_en_o = wb_en_q && !busywait_i;  // retire once, on the released cycle.

    a_branch_no_wb : assert property (
        @(posedge clk_i) disable iff (!arst_n_i) redirect_o |-> !ex_bus.reg_wb_en
    );

endmodule

`default_nettype wire

// File: rtl/id_ex_stage_reg.sv
`default_nettype none

module id_ex_stage_reg (
    input  wire logic     clk_i,
    input  wire logic     arst_n_i,
    input  wire logic     busywait_i,
    input  wire logic     flush_i,
    input  wire logic     hazard_i,
    input  wire logic     redirect_i,
    id_ex_bus_if.consumer id_bus,
    id_ex_bus_if.producer ex_bus
);

    logic flush_pend;
    logic bubble;

    // a flush seen during busywait is kept for the next capture.
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            flush_pend <= 1'b0;
        end else if (!busywait_i) begin
            flush_pend <= 1'b0;
        end else if (flush_i) begin
            flush_pend <= 1'b1;
        end
    end

    assign bubble = flush_i || flush_pend || hazard_i || redirect_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_bus.branch_sel <= pipe_ctrl_pkg::BR_NONE;
            ex_bus.reg_wb_en  <= 1'b0;
        end else if (!busywait_i) begin
            if (bubble) begin
                ex_bus.branch_sel <= pipe_ctrl_pkg::BR_NONE;
                ex_bus.reg_wb_en  <= 1'b0;
            end else begin
                ex_bus.branch_sel <= id_bus.branch_sel;
                ex_bus.reg_wb_en  <= id_bus.reg_wb_en;
            end
        end
    end

    // payload is don't-care in a bubble.
    always_ff @(posedge clk_i) begin
        if (!busywait_i) begin
            ex_bus.pc        <= id_bus.pc;
            ex_bus.rs1_value <= id_bus.rs1_value;
            ex_bus.rs2_value <= id_bus.rs2_value;
            ex_bus.imm_value <= id_bus.imm_value;
            ex_bus.alu_op    <= id_bus.alu_op;
            ex_bus.alu_a_sel <= id_bus.alu_a_sel;
            ex_bus.alu_b_sel <= id_bus.alu_b_sel;
            ex_bus.rd        <= id_bus.rd;
            ex_bus.rs1_label <= id_bus.rs1_label;
            ex_bus.rs2_label <= id_bus.rs2_label;
        end
    end

    // the whole held instruction, payload included, stays put while busy.
    a_hold_on_busywait : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        busywait_i |=> ($stable(ex_bus.reg_wb_en) && $stable(ex_bus.branch_sel) &&
                        $stable(ex_bus.pc) && $stable(ex_bus.rd) &&
                        $stable(ex_bus.rs1_value) && $stable(ex_bus.rs2_value) &&
                        $stable(ex_bus.imm_value) && $stable(ex_bus.alu_op) &&
                        $stable(ex_bus.alu_a_sel) && $stable(ex_bus.alu_b_sel))
    );

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
`default_nettype none

`include "core_settings.svh"

module decode_stage (
    input  wire logic                 clk_i,
    input  wire logic                 arst_n_i,
    input  wire rv_isa_pkg::pc_t      pc_i,
    input  wire rv_isa_pkg::word_t    instr_i,
    id_ex_bus_if.producer             id_bus,
    input  wire rv_isa_pkg::reg_idx_t ex_rd_i,
    input  wire logic                 ex_wb_en_i,
    output logic                      hazard_o,
    input  wire logic                 wb_en_i,
    input  wire rv_isa_pkg::reg_idx_t wb_rd_i,
    input  wire rv_isa_pkg::word_t    wb_data_i
);

    rv_isa_pkg::word_t     instr;
    rv_isa_pkg::opcode_t   opcode;
    rv_isa_pkg::funct3_t   funct3;
    rv_isa_pkg::funct7_t   funct7;
    logic                  uses_rs1;
    logic                  uses_rs2;

    // unsupported opcodes decode as the canonical nop.
    always_comb begin
        case (instr_i[6:0])
            rv_isa_pkg::OPC_OP,
            rv_isa_pkg::OPC_OP_IMM,
            rv_isa_pkg::OPC_LUI,
            rv_isa_pkg::OPC_BRANCH: instr = instr_i;
            default:                instr = `NOP_INSTR;
        endcase
    end

    assign opcode           = instr[6:0];
    assign funct3           = instr[14:12];
    assign funct7           = instr[31:25];
    assign id_bus.pc        = pc_i;
    assign id_bus.rd        = instr[11:7];
    assign id_bus.rs1_label = instr[19:15];
    assign id_bus.rs2_label = instr[24:20];

    reg_file u_reg_file (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .rs1_idx_i  (instr[19:15]),
        .rs2_idx_i  (instr[24:20]),
        .rs1_data_o (id_bus.rs1_value),
        .rs2_data_o (id_bus.rs2_value),
        .wr_en_i    (wb_en_i),
        .wr_idx_i   (wb_rd_i),
        .wr_data_i  (wb_data_i)
    );

    always_comb begin
        id_bus.alu_op     = pipe_ctrl_pkg::ALU_ADD;
        id_bus.alu_a_sel  = pipe_ctrl_pkg::SEL_A_REG;
        id_bus.alu_b_sel  = pipe_ctrl_pkg::SEL_B_REG;
        id_bus.branch_sel = pipe_ctrl_pkg::BR_NONE;
        id_bus.reg_wb_en  = 1'b0;
        id_bus.imm_value  = {{(`XLEN-12){instr[31]}}, instr[31:20]};  // i-type.
        uses_rs1          = 1'b0;
        uses_rs2          = 1'b0;
        case (opcode)
            rv_isa_pkg::OPC_OP: begin
                uses_rs1         = 1'b1;
                uses_rs2         = 1'b1;
                id_bus.reg_wb_en = 1'b1;
                case (funct3)
                    rv_isa_pkg::F3_ADD_SUB: id_bus.alu_op = (funct7 == rv_isa_pkg::F7_SUB) ?
                        pipe_ctrl_pkg::ALU_SUB : pipe_ctrl_pkg::ALU_ADD;
                    rv_isa_pkg::F3_SLL:     id_bus.alu_op = pipe_ctrl_pkg::ALU_SLL;
                    rv_isa_pkg::F3_SLT:     id_bus.alu_op = pipe_ctrl_pkg::ALU_SLT;
                    rv_isa_pkg::F3_XOR:     id_bus.alu_op = pipe_ctrl_pkg::ALU_XOR;
                    rv_isa_pkg::F3_SRL:     id_bus.alu_op = pipe_ctrl_pkg::ALU_SRL;
                    rv_isa_pkg::F3_OR:      id_bus.alu_op = pipe_ctrl_pkg::ALU_OR;
                    rv_isa_pkg::F3_AND:     id_bus.alu_op = pipe_ctrl_pkg::ALU_AND;
                    default:                id_bus.reg_wb_en = 1'b0;    // sltu.
                endcase
                if ((funct3 == rv_isa_pkg::F3_SRL) && (funct7 == rv_isa_pkg::F7_SUB)) begin
                    id_bus.reg_wb_en = 1'b0;    // sra is not in the subset.
                end
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                uses_rs1         = 1'b1;
                id_bus.alu_b_sel = pipe_ctrl_pkg::SEL_B_IMM;
                id_bus.reg_wb_en = 1'b1;
                case (funct3)
                    rv_isa_pkg::F3_ADD_SUB: id_bus.alu_op = pipe_ctrl_pkg::ALU_ADD;
                    rv_isa_pkg::F3_SLT:     id_bus.alu_op = pipe_ctrl_pkg::ALU_SLT;
                    rv_isa_pkg::F3_XOR:     id_bus.alu_op = pipe_ctrl_pkg::ALU_XOR;
                    rv_isa_pkg::F3_OR:      id_bus.alu_op = pipe_ctrl_pkg::ALU_OR;
                    rv_isa_pkg::F3_AND:     id_bus.alu_op = pipe_ctrl_pkg::ALU_AND;
                    default:                id_bus.reg_wb_en = 1'b0;
                endcase
            end
            rv_isa_pkg::OPC_LUI: begin
                id_bus.alu_op    = pipe_ctrl_pkg::ALU_PASS_B;
                id_bus.alu_a_sel = pipe_ctrl_pkg::SEL_A_ZERO;
                id_bus.alu_b_sel = pipe_ctrl_pkg::SEL_B_IMM;
                id_bus.imm_value = {instr[31:12], 12'b0};
                id_bus.reg_wb_en = 1'b1;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                uses_rs1         = 1'b1;
                uses_rs2         = 1'b1;
                id_bus.imm_value = {{(`XLEN-12){instr[31]}}, instr[7], instr[30:25],
                                    instr[11:8], 1'b0};
                case (funct3)
                    rv_isa_pkg::F3_BEQ: id_bus.branch_sel = pipe_ctrl_pkg::BR_EQ;
                    rv_isa_pkg::F3_BNE: id_bus.branch_sel = pipe_ctrl_pkg::BR_NE;
                    default:            id_bus.branch_sel = pipe_ctrl_pkg::BR_NONE;
                endcase
            end
            default: ;
        endcase
        if (instr[11:7] == '0) begin
            id_bus.reg_wb_en = 1'b0;    // results to x0 are dropped here.
        end
    end

    // only a producer still in EX is a conflict, WB goes through the bypass.
    assign hazard_o = ex_wb_en_i && (ex_rd_i != '0) &&
                      ((uses_rs1 && (instr[19:15] == ex_rd_i)) ||
                       (uses_rs2 && (instr[24:20] == ex_rd_i)));

endmodule

`default_nettype wire

// File: rtl/reg_file.sv
`default_nettype none

`include "core_settings.svh"

module reg_file (
    input  wire logic                 clk_i,
    input  wire logic                 arst_n_i,
    input  wire rv_isa_pkg::reg_idx_t rs1_idx_i,
    input  wire rv_isa_pkg::reg_idx_t rs2_idx_i,
    output rv_isa_pkg::word_t         rs1_data_o,
    output rv_isa_pkg::word_t         rs2_data_o,
    input  wire logic                 wr_en_i,
    input  wire rv_isa_pkg::reg_idx_t wr_idx_i,
    input  wire rv_isa_pkg::word_t    wr_data_i
);

    rv_isa_pkg::word_t regs [1:`REG_COUNT-1];   // x0 has no storage.

    function automatic rv_isa_pkg::word_t read_port(input rv_isa_pkg::reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end else if (wr_en_i && (wr_idx_i == idx)) begin
            return wr_data_i;                   // write-through bypass.
        end
        return regs[idx];
    endfunction

    always_ff @(posedge clk_i) begin
        if (wr_en_i && (wr_idx_i != '0)) begin
            regs[wr_idx_i] <= wr_data_i;
        end
    end

    always_comb begin
        rs1_data_o = read_port(rs1_idx_i);
        rs2_data_o = read_port(rs2_idx_i);
    end

    // decode drops the write enable for rd = x0, so no write to x0 reaches here.
    a_no_x0_write : assert property (
        @(posedge clk_i) disable iff (!arst_n_i) !(wr_en_i && (wr_idx_i == '0))
    );

endmodule

`default_nettype wire

// File: rtl/id_ex_bus_if.sv
`default_nettype none

interface id_ex_bus_if;

    rv_isa_pkg::pc_t              pc;
    rv_isa_pkg::word_t            rs1_value;
    rv_isa_pkg::word_t            rs2_value;
    rv_isa_pkg::word_t            imm_value;
    pipe_ctrl_pkg::alu_op_t       alu_op;
    pipe_ctrl_pkg::op_sel_t       alu_a_sel;
    pipe_ctrl_pkg::op_sel_t       alu_b_sel;
    pipe_ctrl_pkg::branch_sel_t   branch_sel;
    logic                         reg_wb_en;
    rv_isa_pkg::reg_idx_t         rd;
    rv_isa_pkg::reg_idx_t         rs1_label;
    rv_isa_pkg::reg_idx_t         rs2_label;

    modport producer (
        output pc, rs1_value, rs2_value, imm_value, alu_op, alu_a_sel, alu_b_sel,
        output branch_sel, reg_wb_en, rd, rs1_label, rs2_label
    );

    modport consumer (
        input pc, rs1_value, rs2_value, imm_value, alu_op, alu_a_sel, alu_b_sel,
        input branch_sel, reg_wb_en, rd, rs1_label, rs2_label
    );

endinterface

`default_nettype wire

// File: rtl/pipe_ctrl_pkg.sv
`default_nettype none

package pipe_ctrl_pkg;

    typedef logic [3:0] alu_op_t;

    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_AND    = 4'd2;
    localparam alu_op_t ALU_OR     = 4'd3;
    localparam alu_op_t ALU_XOR    = 4'd4;
    localparam alu_op_t ALU_SLT    = 4'd5;
    localparam alu_op_t ALU_SLL    = 4'd6;
    localparam alu_op_t ALU_SRL    = 4'd7;
    localparam alu_op_t ALU_PASS_B = 4'd8;     // lui.

    typedef logic op_sel_t;

    localparam op_sel_t SEL_A_REG  = 1'b0;
    localparam op_sel_t SEL_A_ZERO = 1'b1;
    localparam op_sel_t SEL_B_REG  = 1'b0;
    localparam op_sel_t SEL_B_IMM  = 1'b1;

    typedef logic [1:0] branch_sel_t;

    localparam branch_sel_t BR_NONE = 2'd0;   // carried by bubbles.
    localparam branch_sel_t BR_EQ   = 2'd1;
    localparam branch_sel_t BR_NE   = 2'd2;

endpackage

`default_nettype wire

// File: rtl/rv_isa_pkg.sv
`default_nettype none

`include "core_settings.svh"

package rv_isa_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`XLEN-1:2] pc_t;     // byte offset bits are implied zero.
    typedef logic [4:0]       reg_idx_t;
    typedef logic [6:0]       opcode_t;
    typedef logic [2:0]       funct3_t;
    typedef logic [6:0]       funct7_t;

    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;

    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL     = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    localparam funct3_t F3_BEQ = 3'b000;
    localparam funct3_t F3_BNE = 3'b001;

    localparam funct7_t F7_SUB = 7'b0100000;    // also marks sra.

endpackage

`default_nettype wire

// File: rtl/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

`define XLEN 32
`define REG_COUNT 32

// addi x0, x0, 0
`define NOP_INSTR 32'h0000_0013

`endif
